//--- logic/stream_alu.sv
// One-beat registered stage with wrap-around arithmetic and a free-running 32-bit delivery count
`timescale 1ns/1ps
`include "stream_defs.svh"

module stream_alu (
    input  logic              clk,
    input  logic              reset,
    input  stream_pkg::cfg_t  cfg,
    input  stream_pkg::beat_t s_beat,
    input  logic              s_valid,
    output logic              s_ready,
    output stream_pkg::beat_t m_beat,
    output logic              m_valid,
    input  logic              m_ready,
    output logic [31:0]       beat_count
);

    logic [`STREAM_DATA_W-1:0] result;
    logic                      advance;
    logic                      valid_q;
    stream_pkg::beat_t         beat_q;

    always_comb begin
        case (cfg.op)
            stream_pkg::OP_ADD: result = s_beat.data + cfg.operand;
            stream_pkg::OP_SUB: result = s_beat.data - cfg.operand;
            stream_pkg::OP_XOR: result = s_beat.data ^ cfg.operand;
            default:            result = s_beat.data;
        endcase
    end

    // Stage moves only when enabled and the held result can leave
    assign advance = cfg.enable && (!valid_q || m_ready);
    assign s_ready = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && s_valid) begin
            beat_q.data <= result;
            beat_q.last <= s_beat.last;
        end
    end

    assign m_beat  = beat_q;
    assign m_valid = valid_q && cfg.enable;

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_count <= '0;
        end else if (m_valid && m_ready) begin
            beat_count <= beat_count + 32'd1;
        end
    end

endmodule

//--- logic/stream_cfg_regs.sv
// Full-word AXI4-Lite slave with OKAY-only responses and one transaction in flight per direction
`timescale 1ns/1ps
`include "stream_defs.svh"

module stream_cfg_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`AXIL_DATA_W-1:0] wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`AXIL_DATA_W-1:0] rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output stream_pkg::cfg_t        cfg,
    input  logic [31:0]             beat_count
);

    logic                    wr_fire;
    logic                    rd_fire;
    logic [`AXIL_DATA_W-1:0] rd_word;

    // awready and wready always pulse together
    assign wr_fire = awvalid && wvalid && awready;
    assign rd_fire = arvalid && arready;

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= 1'b0;
            wready  <= 1'b0;
            if (awvalid && wvalid && !awready && !bvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '{enable: 1'b0, op: stream_pkg::OP_PASS, operand: '0};
        end else if (wr_fire) begin
            case (awaddr)
                `REG_CTRL:    cfg.enable  <= wdata[0];
                `REG_OP:      cfg.op      <= stream_pkg::op_e'(wdata[1:0]);
                `REG_OPERAND: cfg.operand <= wdata[`STREAM_DATA_W-1:0];
                // COUNT and unmapped offsets take no write
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_word = '0;
        case (araddr)
            `REG_CTRL:    rd_word[0]                  = cfg.enable;
            `REG_OP:      rd_word[1:0]                = cfg.op;
            `REG_OPERAND: rd_word[`STREAM_DATA_W-1:0] = cfg.operand;
            `REG_COUNT:   rd_word                     = beat_count;
            default:      rd_word                     = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

endmodule

//--- logic/stream_defs.svh
// Data and AXI4-Lite widths plus byte offsets of the register map
`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

`define STREAM_DATA_W 16

`define AXIL_ADDR_W 4
`define AXIL_DATA_W 32

// Register offsets
`define REG_CTRL    4'h0
`define REG_OP      4'h4
`define REG_OPERAND 4'h8
`define REG_COUNT   4'hC

`endif

//--- logic/stream_ff.sv
// Handshakes are masked while cke is low so a frozen slice neither accepts nor delivers a beat
`timescale 1ns/1ps

module stream_ff #(
    parameter bit S_REGS = 1'b1,
    parameter bit M_REGS = 1'b1
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cke,
    input  stream_pkg::beat_t s_beat,
    input  logic              s_valid,
    output logic              s_ready,
    output stream_pkg::beat_t m_beat,
    output logic              m_valid,
    input  logic              m_ready
);

    stream_pkg::beat_t mid_beat;
    logic              mid_valid;
    logic              mid_ready;

    if (S_REGS) begin : g_skid
        logic              ready_q;
        logic              ready_d;
        logic              buf_valid_q;
        logic              buf_valid_d;
        logic              buf_load;
        stream_pkg::beat_t buf_beat_q;

        always_comb begin
            ready_d     = ready_q;
            buf_valid_d = buf_valid_q;
            buf_load    = 1'b0;
            if (s_valid && ready_q && !buf_valid_q && !mid_ready) begin
                // Downstream stalled so park the beat and close the input
                ready_d     = 1'b0;
                buf_valid_d = 1'b1;
                buf_load    = 1'b1;
            end else begin
                if (mid_ready) begin
                    buf_valid_d = 1'b0;
                end
                if (!mid_valid || mid_ready) begin
                    ready_d = 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                ready_q     <= 1'b0;
                buf_valid_q <= 1'b0;
            end else if (cke) begin
                ready_q     <= ready_d;
                buf_valid_q <= buf_valid_d;
            end
        end

        always_ff @(posedge clk) begin
            if (cke && buf_load) begin
                buf_beat_q <= s_beat;
            end
        end

        // Skid entry has priority since it arrived first
        assign mid_beat  = buf_valid_q ? buf_beat_q : s_beat;
        assign mid_valid = buf_valid_q || (s_valid && ready_q);
        assign s_ready   = ready_q && cke;
    end else begin : g_s_bypass
        assign mid_beat  = s_beat;
        assign mid_valid = s_valid;
        assign s_ready   = mid_ready && cke;
    end

    if (M_REGS) begin : g_out_reg
        logic              valid_q;
        stream_pkg::beat_t beat_q;

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q <= 1'b0;
            end else if (cke && mid_ready) begin
                valid_q <= mid_valid;
            end
        end

        always_ff @(posedge clk) begin
            if (cke && mid_ready && mid_valid) begin
                beat_q <= mid_beat;
            end
        end

        assign mid_ready = !valid_q || m_ready;
        assign m_beat    = beat_q;
        assign m_valid   = valid_q && cke;
    end else begin : g_m_bypass
        assign mid_ready = m_ready;
        assign m_beat    = mid_beat;
        assign m_valid   = mid_valid && cke;
    end

endmodule

//--- logic/stream_pkg.sv
// Beat and configuration types used across the stream pipeline and its register block
`include "stream_defs.svh"

package stream_pkg;

    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_ADD  = 2'd1,
        OP_SUB  = 2'd2,
        OP_XOR  = 2'd3
    } op_e;

    // Payload of every stream port
    typedef struct packed {
        logic [`STREAM_DATA_W-1:0] data;
        logic                      last;
    } beat_t;

    typedef struct packed {
        logic                      enable;
        op_e                       op;
        logic [`STREAM_DATA_W-1:0] operand;
    } cfg_t;

endpackage

//--- logic/stream_proc_top.sv
// Input slice then ALU then output slice with the register enable freezing every stage
`timescale 1ns/1ps
`include "stream_defs.svh"

module stream_proc_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`AXIL_DATA_W-1:0] wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`AXIL_DATA_W-1:0] rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    input  stream_pkg::beat_t       s_beat,
    input  logic                    s_valid,
    output logic                    s_ready,
    output stream_pkg::beat_t       m_beat,
    output logic                    m_valid,
    input  logic                    m_ready
);

    stream_pkg::cfg_t  cfg;
    logic [31:0]       beat_count;
    stream_pkg::beat_t in_beat;
    logic              in_valid;
    logic              in_ready;
    stream_pkg::beat_t alu_beat;
    logic              alu_valid;
    logic              alu_ready;

    stream_ff #(
        .S_REGS (1'b1),
        .M_REGS (1'b1)
    ) i_in_ff (
        .clk     (clk),
        .reset   (reset),
        .cke     (cfg.enable),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (in_beat),
        .m_valid (in_valid),
        .m_ready (in_ready)
    );

    stream_alu i_alu (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .s_beat     (in_beat),
        .s_valid    (in_valid),
        .s_ready    (in_ready),
        .m_beat     (alu_beat),
        .m_valid    (alu_valid),
        .m_ready    (alu_ready),
        .beat_count (beat_count)
    );

    stream_ff #(
        .S_REGS (1'b0),
        .M_REGS (1'b1)
    ) i_out_ff (
        .clk     (clk),
        .reset   (reset),
        .cke     (cfg.enable),
        .s_beat  (alu_beat),
        .s_valid (alu_valid),
        .s_ready (alu_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    stream_cfg_regs i_cfg (
        .clk        (clk),
        .reset      (reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .cfg        (cfg),
        .beat_count (beat_count)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_stream_proc \
    -f sources.f \
    -o tb_stream_proc

./obj_dir/tb_stream_proc > sim.log 2>&1
cat sim.log

if grep -qx "sim passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

//--- sources.f
+incdir+logic
logic/stream_pkg.sv
logic/stream_ff.sv
logic/stream_alu.sv
logic/stream_cfg_regs.sv
logic/stream_proc_top.sv
testbench/stream_checker.sv
testbench/tb_stream_proc.sv

//--- testbench/stream_checker.sv
// Expects op and operand to stay fixed while beats are in flight; samples everything on the rising edge
`timescale 1ns/1ps
`include "stream_defs.svh"

module stream_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  stream_pkg::beat_t       s_beat,
    input  logic                    s_valid,
    input  logic                    s_ready,
    input  stream_pkg::beat_t       m_beat,
    input  logic                    m_valid,
    input  logic                    m_ready,
    input  logic [`AXIL_ADDR_W-1:0] awaddr,
    input  logic                    awvalid,
    input  logic                    awready,
    input  logic [`AXIL_DATA_W-1:0] wdata,
    input  logic                    wvalid,
    input  logic                    wready,
    input  logic [1:0]              bresp,
    input  logic                    bvalid,
    input  logic                    bready,
    input  logic [`AXIL_ADDR_W-1:0] araddr,
    input  logic                    arvalid,
    input  logic                    arready,
    input  logic [`AXIL_DATA_W-1:0] rdata,
    input  logic [1:0]              rresp,
    input  logic                    rvalid,
    input  logic                    rready,
    input  logic                    check_latency,
    output int                      errors,
    output int                      in_count,
    output int                      out_count
);

    stream_pkg::beat_t         exp_q[$];
    int                        accept_cycle_q[$];
    int                        err_cnt = 0;
    int                        cycle;
    int                        latency;
    stream_pkg::beat_t         exp_beat;
    logic                      en_m;
    stream_pkg::op_e           op_m;
    logic [`STREAM_DATA_W-1:0] operand_m;
    logic [`AXIL_DATA_W-1:0]   rd_exp;
    logic                      reset_d;
    logic                      frozen_q;
    logic                      frozen_m_valid;

    assign errors = err_cnt;

    task automatic report(input string what, input logic [31:0] exp_val,
                          input logic [31:0] act_val);
        $display("[ERROR] %0t: %s expected %h, actual %h", $time, what, exp_val, act_val);
        err_cnt++;
    endtask

    // Arithmetic wraps modulo 2^16 and the last flag is carried as is
    function automatic stream_pkg::beat_t apply_op(stream_pkg::beat_t b);
        logic [`STREAM_DATA_W:0] wide;
        stream_pkg::beat_t       r;
        r = b;
        case (op_m)
            stream_pkg::OP_ADD: wide = {1'b0, b.data} + {1'b0, operand_m};
            stream_pkg::OP_SUB: wide = {1'b1, b.data} - {1'b0, operand_m};
            stream_pkg::OP_XOR: wide = {1'b0, b.data ^ operand_m};
            default:            wide = {1'b0, b.data};
        endcase
        r.data = wide[`STREAM_DATA_W-1:0];
        return r;
    endfunction

    function automatic logic [`AXIL_DATA_W-1:0] reg_value(logic [`AXIL_ADDR_W-1:0] addr);
        logic [`AXIL_DATA_W-1:0] v;
        v = '0;
        case (addr)
            `REG_CTRL:    v[0] = en_m;
            `REG_OP:      v[1:0] = op_m;
            `REG_OPERAND: v[`STREAM_DATA_W-1:0] = operand_m;
            `REG_COUNT:   v = 32'(out_count);
            default:      v = '0;
        endcase
        return v;
    endfunction

    always @(posedge clk) begin
        reset_d <= reset;
        if (reset) begin
            exp_q.delete();
            accept_cycle_q.delete();
            cycle     <= 0;
            in_count  <= 0;
            out_count <= 0;
            en_m      <= 1'b0;
            op_m      <= stream_pkg::OP_PASS;
            operand_m <= '0;
            frozen_q  <= 1'b0;
        end else begin
            cycle <= cycle + 1;
            if (reset_d && (m_valid || s_ready || awready || wready || bvalid || arready
                            || rvalid)) begin
                report("outputs low after reset", 32'd0,
                       {25'd0, m_valid, s_ready, awready, wready, bvalid, arready, rvalid});
            end
            if (s_valid && s_ready) begin
                exp_q.push_back(apply_op(s_beat));
                accept_cycle_q.push_back(cycle);
                in_count <= in_count + 1;
            end
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    $display("[ERROR] %0t: output beat arrived with no input beat pending", $time);
                    err_cnt++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    latency  = cycle - accept_cycle_q.pop_front();
                    if (m_beat != exp_beat) begin
                        report("output beat", 32'(exp_beat), 32'(m_beat));
                    end
                    if (check_latency && latency != 3) begin
                        report("latency in cycles", 32'd3, 32'(latency));
                    end
                end
                out_count <= out_count + 1;
            end
            // Pipeline frozen
            if (!en_m) begin
                if ((s_valid && s_ready) || (m_valid && m_ready)) begin
                    $display("[ERROR] %0t: a beat moved while the pipeline was disabled", $time);
                    err_cnt++;
                end
                if (frozen_q && m_valid != frozen_m_valid) begin
                    report("m_valid held while disabled", 32'(frozen_m_valid), 32'(m_valid));
                end
                frozen_q       <= 1'b1;
                frozen_m_valid <= m_valid;
            end else begin
                frozen_q <= 1'b0;
            end
            // Every response is OKAY
            if (bvalid && bready && bresp != 2'b00) begin
                report("write response", 32'd0, 32'(bresp));
            end
            if (rvalid && rready && rresp != 2'b00) begin
                report("read response", 32'd0, 32'(rresp));
            end
            if (arvalid && arready) begin
                rd_exp <= reg_value(araddr);
            end
            if (rvalid && rready && rdata != rd_exp) begin
                report("register read", rd_exp, rdata);
            end
            if (awvalid && wvalid && awready) begin
                case (awaddr)
                    `REG_CTRL:    en_m <= wdata[0];
                    `REG_OP:      op_m <= stream_pkg::op_e'(wdata[1:0]);
                    `REG_OPERAND: operand_m <= wdata[`STREAM_DATA_W-1:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- testbench/tb_stream_proc.sv
// Random bursts for all four opcodes from $urandom seed 32'h4f63; run length bounded by a watchdog
`timescale 1ns/1ps
`include "stream_defs.svh"

module tb_stream_proc;

    localparam int BURSTS     = 4;
    localparam int BURST_LEN  = 64;
    localparam int TIMEOUT_CY = BURSTS * BURST_LEN * 20 + 2000;

    logic                    clk = 1'b0;
    logic                    reset;
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    logic [`AXIL_DATA_W-1:0] rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;
    stream_pkg::beat_t       s_beat;
    logic                    s_valid;
    logic                    s_ready;
    stream_pkg::beat_t       m_beat;
    logic                    m_valid;
    // Only the back-pressure process below drives it
    logic                    m_ready = 1'b1;
    logic                    bp_on;
    logic                    check_latency;
    int                      errors;
    int                      in_count;
    int                      out_count;

    stream_proc_top i_dut (
        .clk(clk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .s_beat(s_beat), .s_valid(s_valid), .s_ready(s_ready),
        .m_beat(m_beat), .m_valid(m_valid), .m_ready(m_ready)
    );

    stream_checker i_chk (
        .clk(clk), .reset(reset),
        .s_beat(s_beat), .s_valid(s_valid), .s_ready(s_ready),
        .m_beat(m_beat), .m_valid(m_valid), .m_ready(m_ready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .check_latency(check_latency),
        .errors(errors), .in_count(in_count), .out_count(out_count)
    );

    always #4 clk = ~clk;

    // Output stalls on about one cycle in four
    always @(posedge clk) begin
        m_ready <= bp_on ? ($urandom % 4 != 0) : 1'b1;
    end

    task automatic axi_write(input logic [`AXIL_ADDR_W-1:0] addr,
                             input logic [`AXIL_DATA_W-1:0] data);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(posedge clk);
        while (!awready) @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        @(posedge clk);
        while (!bvalid) @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [`AXIL_ADDR_W-1:0] addr);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        arvalid <= 1'b0;
        @(posedge clk);
        while (!rvalid) @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic send_beat(input stream_pkg::beat_t b);
        s_beat  <= b;
        s_valid <= 1'b1;
        @(posedge clk);
        while (!s_ready) @(posedge clk);
        s_valid <= 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        while (in_count != out_count) @(posedge clk);
    endtask

    task automatic run_burst(input stream_pkg::op_e op, input bit freeze);
        stream_pkg::beat_t b;
        axi_write(`REG_OP, 32'(op));
        axi_write(`REG_OPERAND, {16'd0, 16'($urandom)});
        for (int i = 0; i < BURST_LEN; i++) begin
            b.data = 16'($urandom);
            b.last = (i == BURST_LEN - 1);
            if (freeze && i == BURST_LEN / 2) begin
                // Disable right behind the previous beat so it is still inside the stages
                axi_write(`REG_CTRL, 32'd0);
                // Offer the next beat while frozen
                s_beat  <= b;
                s_valid <= 1'b1;
                repeat (10) @(posedge clk);
                s_valid <= 1'b0;
                axi_write(`REG_CTRL, 32'd1);
            end else begin
                repeat ($urandom % 3) @(posedge clk);
            end
            send_beat(b);
        end
        drain();
        axi_read(`REG_COUNT);
    endtask

    initial begin
        stream_pkg::beat_t b;
        void'($urandom(32'h4f63));
        reset         <= 1'b1;
        awaddr        <= '0;
        awvalid       <= 1'b0;
        wdata         <= '0;
        wvalid        <= 1'b0;
        bready        <= 1'b0;
        araddr        <= '0;
        arvalid       <= 1'b0;
        rready        <= 1'b0;
        s_beat        <= '0;
        s_valid       <= 1'b0;
        bp_on         <= 1'b0;
        check_latency <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        axi_write(`REG_CTRL, 32'd1);

        // Single beat with the output always ready
        check_latency <= 1'b1;
        b.data = 16'h5a5a;
        b.last = 1'b1;
        send_beat(b);
        drain();
        check_latency <= 1'b0;

        axi_write(`REG_OP, 32'd3);
        axi_write(`REG_OPERAND, 32'h0000_beef);
        axi_read(`REG_CTRL);
        axi_read(`REG_OP);
        axi_read(`REG_OPERAND);
        axi_read(4'h6);
        axi_write(`REG_COUNT, 32'h0000_1234);
        axi_read(`REG_COUNT);

        bp_on <= 1'b1;
        run_burst(stream_pkg::OP_PASS, 1'b0);
        run_burst(stream_pkg::OP_ADD, 1'b0);
        run_burst(stream_pkg::OP_SUB, 1'b1);
        run_burst(stream_pkg::OP_XOR, 1'b0);

        $display("beats in %0d, beats out %0d, errors %0d", in_count, out_count, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CY) @(posedge clk);
        $display("timeout: stream stalled");
        $display("sim failed");
        $finish;
    end

endmodule
